/* Bender.yml */
package:
  name: execute

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/pipe_pkg.sv
      - execute/exec_alu.sv
      - execute/exec_intcalc.sv
      - execute/exec_branch.sv
      - execute/exec_control.sv
      - execute/execute.sv
      - target: test
        files:
          - test/exec_checker.sv
          - test/tb_execute.sv

/* common/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define EXEC_VECT_RESET 32'hffffffc0
`define EXEC_INT_DELAY 4'd4
`define EXEC_TRAP_BASE 32'd3

`endif

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_ALU    = 4'h1,
    T_CMP    = 4'h2,
    T_INT    = 4'h3,
    T_INTU   = 4'h4,
    T_LOAD   = 4'h5,
    T_STORE  = 4'h6,
    T_LDI    = 4'h7,
    T_MOV    = 4'h8,
    T_BRANCH = 4'h9,
    T_JUMP   = 4'ha
  } instr_type_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'h0,
    ALU_SUB = 3'h1,
    ALU_AND = 3'h2,
    ALU_OR  = 3'h3,
    ALU_XOR = 3'h4,
    ALU_SHL = 3'h5,
    ALU_SHR = 3'h6,
    ALU_ASR = 3'h7
  } alu_func_t;

  // bit 3 selects unsigned
  typedef enum logic [3:0] {
    INT_MUL  = 4'h0,
    INT_DIV  = 4'h1,
    INT_MOD  = 4'h2,
    INT_MULU = 4'h8,
    INT_DIVU = 4'h9,
    INT_MODU = 4'ha
  } int_func_t;

  typedef struct packed {
    logic ltu;
    logic lt;
    logic eq;
  } ccr_t;

endpackage

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  typedef struct packed {
    logic [63:0] ir;
    logic [31:0] pc;
    logic [31:0] reg_data1;
    logic [31:0] reg_data2;
    logic [1:0]  reg_write;
  } exec_in_t;

  // pc holds the redirect target when pc_set is high
  typedef struct packed {
    logic [63:0] ir;
    logic [31:0] pc;
    logic [31:0] result;
    logic [31:0] reg_data1;
    logic [1:0]  reg_write;
  } exec_out_t;

endpackage

`default_nettype wire

/* execute/exec_alu.sv */
`default_nettype none

module exec_alu (
  input  wire logic [31:0]        in1_i,
  input  wire logic [31:0]        in2_i,
  input  wire isa_pkg::alu_func_t func_i,
  output logic [31:0]             out_o,
  output logic                    c_o,
  output logic                    n_o,
  output logic                    v_o,
  output logic                    z_o
);

  import isa_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;

  assign sum  = {1'b0, in1_i} + {1'b0, in2_i};
  assign diff = {1'b0, in1_i} - {1'b0, in2_i};

  always_comb
  begin
    c_o = 1'b0;
    v_o = 1'b0;
    case (func_i)
      ALU_ADD:
      begin
        out_o = sum[31:0];
        c_o   = sum[32];
        v_o   = (in1_i[31] == in2_i[31]) && (sum[31] != in1_i[31]);
      end
      ALU_SUB:
      begin
        out_o = diff[31:0];
        c_o   = diff[32]; // borrow, so unsigned less
        v_o   = (in1_i[31] != in2_i[31]) && (diff[31] != in1_i[31]);
      end
      ALU_AND: out_o = in1_i & in2_i;
      ALU_OR:  out_o = in1_i | in2_i;
      ALU_XOR: out_o = in1_i ^ in2_i;
      ALU_SHL: out_o = in1_i << in2_i[4:0];
      ALU_SHR: out_o = in1_i >> in2_i[4:0];
      default: out_o = $signed(in1_i) >>> in2_i[4:0];
    endcase
  end

  assign n_o = out_o[31];
  assign z_o = (out_o == 32'h0);

endmodule

`default_nettype wire

/* execute/exec_branch.sv */
`default_nettype none

module exec_branch (
  input  wire isa_pkg::instr_type_t type_i,
  input  wire logic [3:0]           op_i,
  input  wire logic                 size_i,
  input  wire logic [31:0]          ext_addr_i,
  input  wire logic [31:0]          target_i,
  input  wire isa_pkg::ccr_t        ccr_i,
  input  wire logic [31:0]          pc_i,
  output logic [31:0]               pc_o,
  output logic                      take_o
);

  import isa_pkg::*;

  logic cond;
  logic [31:0] dest;

  always_comb
  begin
    case (op_i)
      4'h0:    cond = 1'b1;                       // bra
      4'h1:    cond = ccr_i.eq;
      4'h2:    cond = ~ccr_i.eq;
      4'h3:    cond = ~(ccr_i.ltu | ccr_i.eq);    // gtu
      4'h4:    cond = ~(ccr_i.lt | ccr_i.eq);     // gt
      4'h5:    cond = ~ccr_i.lt;
      4'h6:    cond = ccr_i.lt | ccr_i.eq;
      4'h7:    cond = ccr_i.lt;
      4'h8:    cond = ~ccr_i.ltu;
      4'h9:    cond = ccr_i.ltu;
      4'ha:    cond = ccr_i.ltu | ccr_i.eq;       // leu
      default: cond = 1'b0;
    endcase
  end

  assign take_o = (type_i == T_JUMP) || ((type_i == T_BRANCH) && cond);
  assign dest   = (type_i == T_JUMP && size_i) ? ext_addr_i : target_i;
  assign pc_o   = take_o ? dest : pc_i;

endmodule

`default_nettype wire

/* execute/exec_control.sv */
`default_nettype none

`include "exec_params.svh"

module exec_control (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire logic                 stall_i,
  input  wire isa_pkg::instr_type_t type_i,
  input  wire logic [3:0]           op_i,
  input  wire logic                 size_i,
  input  wire logic [31:0]          ext_addr_i,
  input  wire logic [2:0]           irq_i,
  output logic [31:0]               vectoff_o,
  output logic                      supervisor_o,
  output logic                      int_en_o,
  output logic                      halt_o,
  output logic                      exc_o
);

  import isa_pkg::*;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      vectoff_o    <= `EXEC_VECT_RESET;
      supervisor_o <= 1'b1;
      int_en_o     <= 1'b0;
      halt_o       <= 1'b0;
      exc_o        <= 1'b0;
    end
    else
    begin
      exc_o <= 1'b0;
      if (!stall_i)
      begin
        if (|irq_i && int_en_o)
        begin
          exc_o    <= 1'b1;
          int_en_o <= 1'b0;
        end
        else if (type_i == T_INH)
        begin
          case (op_i)
            4'h1:
              if (size_i)
              begin
                if (supervisor_o)
                  vectoff_o <= ext_addr_i; // set vector base
                else
                  halt_o <= 1'b1;
              end
              else
              begin
                exc_o    <= 1'b1; // trap
                int_en_o <= 1'b0;
              end
            4'h2: int_en_o <= 1'b0;
            4'h3: int_en_o <= 1'b1;
            4'h4: halt_o <= 1'b1;
            4'h5:
              if (supervisor_o)
              begin
                exc_o    <= 1'b1; // soft reset
                int_en_o <= 1'b0;
              end
              else
                halt_o <= 1'b1;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* execute/exec_intcalc.sv */
`default_nettype none

module exec_intcalc (
  input  wire logic [31:0]        a_i,
  input  wire logic [31:0]        b_i,
  input  wire isa_pkg::int_func_t func_i,
  output logic [31:0]             out_o
);

  import isa_pkg::*;

  logic        div_zero;
  logic [31:0] prod;
  logic [31:0] squot, srem, uquot, urem;

  assign div_zero = (b_i == 32'h0);
  assign prod     = a_i * b_i; // low word is the same signed or not

  always_comb
  begin
    if (div_zero)
    begin
      squot = 32'hffffffff;
      uquot = 32'hffffffff;
      srem  = a_i;
      urem  = a_i;
    end
    else
    begin
      squot = $signed(a_i) / $signed(b_i);
      srem  = $signed(a_i) % $signed(b_i);
      uquot = a_i / b_i;
      urem  = a_i % b_i;
    end
  end

  always_comb
  begin
    case (func_i)
      INT_MUL, INT_MULU: out_o = prod;
      INT_DIV:           out_o = squot;
      INT_MOD:           out_o = srem;
      INT_DIVU:          out_o = uquot;
      INT_MODU:          out_o = urem;
      default:           out_o = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

/* execute/execute.sv */
`default_nettype none

`include "exec_params.svh"

module execute (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire pipe_pkg::exec_in_t in_i,
  input  wire logic [2:0]         irq_i,
  input  wire logic               stall_i,
  output pipe_pkg::exec_out_t     out_o,
  output isa_pkg::ccr_t           ccr_o,
  output logic                    pc_set_o,
  output logic                    halt_o,
  output logic                    exc_o,
  output logic                    supervisor_o,
  output logic                    int_en_o,
  output logic                    stall_o
);

  import isa_pkg::*;
  import pipe_pkg::*;

  instr_type_t ir_type;
  logic [3:0]  ir_op;
  logic        ir_size;
  logic [31:0] ir_ext, ir_sval, ir_uval, ir_soff;

  alu_func_t   alu_func;
  int_func_t   int_func;
  logic [31:0] alu_in1, alu_in2, alu_out, int_out;
  logic        alu_c, alu_n, alu_v, alu_z;

  logic [31:0] pc_next, result, vectoff;
  logic        take, hold, stall_start;
  logic [3:0]  delay;
  ccr_t        ccr_next;

  assign ir_ext  = in_i.ir[63:32];
  assign ir_type = instr_type_t'(in_i.ir[31:28]);
  assign ir_op   = in_i.ir[27:24];
  assign ir_sval = {{17{in_i.ir[15]}}, in_i.ir[15:1]};
  assign ir_uval = {17'h0, in_i.ir[15:1]};
  assign ir_size = in_i.ir[0];
  assign ir_soff = {ir_sval[29:0], 2'b00}; // word offset

  assign stall_start = (ir_type == T_INT || ir_type == T_INTU) && (delay == 4'h0);
  assign stall_o     = (delay > 4'h1) || stall_start;
  assign hold        = stall_i || stall_o;

  always_comb
  begin
    alu_in1  = in_i.reg_data1;
    alu_in2  = in_i.reg_data2;
    alu_func = alu_func_t'(ir_op[2:0]);
    int_func = int_func_t'({ir_type == T_INTU, ir_op[2:0]});
    case (ir_type)
      T_ALU, T_INT, T_INTU:
        if (ir_op[3])
          alu_in2 = ir_sval;
      T_CMP: alu_func = ALU_SUB;
      T_LOAD, T_STORE:
      begin
        alu_func = ALU_ADD;
        if (!ir_size)
          alu_in1 = ir_soff;
      end
      T_BRANCH:
      begin
        alu_func = ALU_ADD;
        alu_in1  = in_i.pc;
        alu_in2  = ir_soff;
      end
      T_JUMP:
      begin
        alu_func = ALU_ADD;
        if (!ir_size)
          alu_in2 = ir_soff;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    if (|irq_i && int_en_o)
      result = vectoff + {26'h0, irq_i, 3'b000};
    else
      case (ir_type)
        T_INH:
          if (ir_op == 4'h5)
            result = vectoff; // soft reset
          else if (ir_op == 4'h1 && !ir_size)
            result = vectoff + ((`EXEC_TRAP_BASE + {30'h0, ir_uval[1:0]}) << 3);
          else
            result = alu_out;
        T_INT, T_INTU:   result = int_out;
        T_LOAD, T_STORE: result = ir_size ? ir_ext : alu_out;
        T_LDI:           result = ir_size ? ir_ext : ir_uval;
        T_MOV:           result = in_i.reg_data1;
        default:         result = alu_out;
      endcase
  end

  always_comb
  begin
    ccr_next = ccr_o;
    if (ir_type == T_CMP)
    begin
      ccr_next.ltu = alu_c;
      ccr_next.lt  = alu_n ^ alu_v;
      ccr_next.eq  = alu_z;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      out_o    <= '0;
      ccr_o    <= '0;
      pc_set_o <= 1'b0;
      delay    <= 4'h0;
    end
    else
    begin
      if (stall_start)
        delay <= `EXEC_INT_DELAY;
      else if (delay != 4'h0)
        delay <= delay - 4'h1;
      if (!hold)
      begin
        out_o.ir        <= in_i.ir;
        out_o.pc        <= pc_next;
        out_o.result    <= result;
        out_o.reg_data1 <= in_i.reg_data1;
        out_o.reg_write <= in_i.reg_write;
        ccr_o           <= ccr_next;
        pc_set_o        <= take;
      end
    end
  end

  exec_alu u_alu (
    .in1_i  (alu_in1),
    .in2_i  (alu_in2),
    .func_i (alu_func),
    .out_o  (alu_out),
    .c_o    (alu_c),
    .n_o    (alu_n),
    .v_o    (alu_v),
    .z_o    (alu_z)
  );

  exec_intcalc u_intcalc (
    .a_i    (alu_in1),
    .b_i    (alu_in2),
    .func_i (int_func),
    .out_o  (int_out)
  );

  exec_branch u_branch (
    .type_i     (ir_type),
    .op_i       (ir_op),
    .size_i     (ir_size),
    .ext_addr_i (ir_ext),
    .target_i   (alu_out),
    .ccr_i      (ccr_o),
    .pc_i       (in_i.pc),
    .pc_o       (pc_next),
    .take_o     (take)
  );

  exec_control u_control (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .type_i       (ir_type),
    .op_i         (ir_op),
    .size_i       (ir_size),
    .ext_addr_i   (ir_ext),
    .irq_i        (irq_i),
    .vectoff_o    (vectoff),
    .supervisor_o (supervisor_o),
    .int_en_o     (int_en_o),
    .halt_o       (halt_o),
    .exc_o        (exc_o)
  );

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
execute/exec_alu.sv
execute/exec_intcalc.sv
execute/exec_branch.sv
execute/exec_control.sv
execute/execute.sv
test/exec_checker.sv
test/tb_execute.sv

/* test/exec_checker.sv */
`default_nettype none

`include "exec_params.svh"

module exec_checker (
  input wire logic                clk_i,
  input wire logic                rst_i,
  input wire pipe_pkg::exec_in_t  in_i,
  input wire logic [2:0]          irq_i,
  input wire logic                stall_i,
  input wire pipe_pkg::exec_out_t out_i,
  input wire isa_pkg::ccr_t       ccr_i,
  input wire logic                pc_set_i,
  input wire logic                halt_i,
  input wire logic                exc_i,
  input wire logic                busy_i,
  input wire logic                supervisor_i,
  input wire logic                int_en_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import pipe_pkg::*;

  int          errors;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  exec_out_t   exp_out;
  ccr_t        exp_ccr;
  logic        exp_pc_set, exp_halt, exp_exc, int_en;
  logic [31:0] vbase;
  logic [3:0]  busy_cnt;

  function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] b, logic [2:0] f);
    case (f)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      3'd5: return a << b[4:0];
      3'd6: return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  function automatic logic [31:0] int_ref(logic [31:0] a, logic [31:0] b, logic uns,
                                          logic [2:0] f);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    if (f == 3'd0)
      return a * b;
    if (b == 32'h0)
      return (f == 3'd1) ? 32'hffffffff : a; // divide by zero
    if (f == 3'd1 && uns)
      return a / b;
    if (f == 3'd1)
      return sa / sb;
    if (uns)
      return a % b;
    return sa % sb;
  endfunction

  function automatic logic branch_taken(logic [3:0] op, ccr_t c);
    case (op)
      4'd0:  return 1'b1;
      4'd1:  return c.eq;
      4'd2:  return !c.eq;
      4'd3:  return !c.ltu && !c.eq;
      4'd4:  return !c.lt && !c.eq;
      4'd5:  return !c.lt;
      4'd6:  return c.lt || c.eq;
      4'd7:  return c.lt;
      4'd8:  return !c.ltu;
      4'd9:  return c.ltu;
      4'd10: return c.ltu || c.eq;
      default: return 1'b0;
    endcase
  endfunction

  // stall covers the first four cycles of an integer op
  function automatic logic busy_now();
    logic [3:0] t;
    t = in_i.ir[31:28];
    return (t == T_INT || t == T_INTU) && (busy_cnt < `EXEC_INT_DELAY);
  endfunction

  task automatic compare_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic reset_model();
    exp_out    = '0;
    exp_ccr    = '0;
    exp_pc_set = 1'b0;
    exp_halt   = 1'b0;
    exp_exc    = 1'b0;
    int_en     = 1'b0;
    vbase      = `EXEC_VECT_RESET;
    busy_cnt   = 4'd0;
  endtask

  task automatic check_outputs();
    compare_field("out_o.ir", exp_out.ir, out_i.ir);
    compare_field("out_o.pc", exp_out.pc, out_i.pc);
    compare_field("out_o.result", exp_out.result, out_i.result);
    compare_field("out_o.reg_data1", exp_out.reg_data1, out_i.reg_data1);
    compare_field("out_o.reg_write", exp_out.reg_write, out_i.reg_write);
    compare_field("ccr_o", exp_ccr, ccr_i);
    compare_field("pc_set_o", exp_pc_set, pc_set_i);
    compare_field("halt_o", exp_halt, halt_i);
    compare_field("exc_o", exp_exc, exc_i);
    compare_field("stall_o", busy_now(), busy_i);
    compare_field("supervisor_o", 1'b1, supervisor_i);
    compare_field("int_en_o", int_en, int_en_i);
  endtask

  task automatic step_model();
    instr_type_t t;
    logic [3:0]  op;
    logic        sz, take, accept;
    logic [31:0] a, b, ext, sval, soff, res, npc;
    t      = instr_type_t'(in_i.ir[31:28]);
    op     = in_i.ir[27:24];
    sz     = in_i.ir[0];
    ext    = in_i.ir[63:32];
    sval   = {{17{in_i.ir[15]}}, in_i.ir[15:1]};
    soff   = sval << 2;
    a      = in_i.reg_data1;
    b      = in_i.reg_data2;
    accept = !stall_i && !busy_now();
    take   = 1'b0;
    npc    = in_i.pc;
    case (t)
      T_INH:
        if (op == 4'h5)
          res = vbase;
        else if (op == 4'h1 && !sz)
          res = vbase + ((`EXEC_TRAP_BASE + 32'(in_i.ir[2:1])) << 3); // trap slot
        else
          res = alu_ref(a, b, op[2:0]);
      T_ALU:           res = alu_ref(a, op[3] ? sval : b, op[2:0]);
      T_CMP:           res = a - b;
      T_INT, T_INTU:   res = int_ref(a, op[3] ? sval : b, t == T_INTU, op[2:0]);
      T_LOAD, T_STORE: res = sz ? ext : soff + b;
      T_LDI:           res = sz ? ext : {17'h0, in_i.ir[15:1]};
      T_MOV:           res = a;
      T_BRANCH:
      begin
        res  = in_i.pc + soff;
        take = branch_taken(op, exp_ccr);
        npc  = take ? res : in_i.pc;
      end
      T_JUMP:
      begin
        res  = a + (sz ? b : soff);
        take = 1'b1;
        npc  = sz ? ext : a + soff;
      end
      default:         res = alu_ref(a, b, op[2:0]);
    endcase
    if (|irq_i && int_en)
      res = vbase + 32'(irq_i) * 32'd8; // interrupt vector wins
    if (accept)
    begin
      exp_out.ir        = in_i.ir;
      exp_out.pc        = npc;
      exp_out.result    = res;
      exp_out.reg_data1 = a;
      exp_out.reg_write = in_i.reg_write;
      exp_pc_set        = take;
      if (t == T_CMP)
      begin
        exp_ccr.ltu = a < b;
        exp_ccr.lt  = $signed(a) < $signed(b);
        exp_ccr.eq  = a == b;
      end
    end
    if (busy_now())
      busy_cnt = busy_cnt + 4'd1;
    else
      busy_cnt = 4'd0;
    exp_exc = 1'b0;
    if (!stall_i)
    begin
      if (|irq_i && int_en)
      begin
        exp_exc = 1'b1;
        int_en  = 1'b0;
      end
      else if (t == T_INH)
      begin
        if ((op == 4'h1 && !sz) || op == 4'h5)
        begin
          exp_exc = 1'b1;
          int_en  = 1'b0;
        end
        if (op == 4'h1 && sz)
          vbase = ext;
        if (op == 4'h2)
          int_en = 1'b0;
        if (op == 4'h3)
          int_en = 1'b1;
        if (op == 4'h4)
          exp_halt = 1'b1;
      end
    end
  endtask

  // outputs and inputs both settle well before the falling edge
  always @(negedge clk_i)
  begin
    if (rst_i)
      reset_model();
    else
    begin
      check_outputs();
      step_model();
    end
  end

  task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("%s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
  endtask

endmodule

`default_nettype wire

/* test/tb_execute.sv */
`default_nettype none

module tb_execute;

  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import pipe_pkg::*;

  logic        clk, rst, stall_in, stall_mode;
  logic [2:0]  irq, lvl;
  exec_in_t    dut_in;
  exec_out_t   dut_out;
  ccr_t        ccr;
  logic        pc_set, halt, exc, supervisor, int_en, stall_out;
  logic [31:0] a, b;
  logic [3:0]  op;
  int          seed;

  instr_type_t data_types [5] = '{T_ALU, T_LDI, T_MOV, T_LOAD, T_STORE};
  instr_type_t hold_types [4] = '{T_ALU, T_CMP, T_BRANCH, T_LDI};

  always #5 clk = ~clk;

  execute uut (
    .clk_i        (clk),
    .rst_i        (rst),
    .in_i         (dut_in),
    .irq_i        (irq),
    .stall_i      (stall_in),
    .out_o        (dut_out),
    .ccr_o        (ccr),
    .pc_set_o     (pc_set),
    .halt_o       (halt),
    .exc_o        (exc),
    .supervisor_o (supervisor),
    .int_en_o     (int_en),
    .stall_o      (stall_out)
  );

  exec_checker chk (
    .clk_i        (clk),
    .rst_i        (rst),
    .in_i         (dut_in),
    .irq_i        (irq),
    .stall_i      (stall_in),
    .out_i        (dut_out),
    .ccr_i        (ccr),
    .pc_set_i     (pc_set),
    .halt_i       (halt),
    .exc_i        (exc),
    .busy_i       (stall_out),
    .supervisor_i (supervisor),
    .int_en_i     (int_en)
  );

  function automatic logic [63:0] make_ir(instr_type_t t, logic [3:0] o, logic [14:0] imm,
                                          logic sz, logic [31:0] ext);
    return {ext, t, o, 8'h00, imm, sz};
  endfunction

  // holds the instruction until the stage takes it
  task automatic issue(input logic [63:0] ir, input logic [2:0] level,
                       input logic [31:0] op1, input logic [31:0] op2);
    int   waited;
    logic taken;
    waited           = 0;
    taken            = 1'b0;
    dut_in.ir        = ir;
    dut_in.pc        = $urandom & 32'hfffffffc;
    dut_in.reg_data1 = op1;
    dut_in.reg_data2 = op2;
    dut_in.reg_write = 2'($urandom);
    irq              = level;
    while (!taken)
    begin
      stall_in = stall_mode && ($urandom_range(0, 1) != 0);
      @(negedge clk);
      taken = !stall_in && !stall_out;
      @(posedge clk);
      #1;
      waited++;
      if (!taken && waited > 60)
      begin
        $display("Timed out: the stage did not accept an instruction within 60 cycles");
        $display("Test failures found");
        $finish;
      end
    end
    irq = 3'h0;
  endtask

  // a trailing nop lets the last result be checked inside its own test
  task automatic close_test(input string name);
    stall_mode = 1'b0;
    issue(make_ir(T_INH, 4'h0, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0);
    chk.finish_test(name);
  endtask

  initial
  begin
    seed = 32;
    void'($urandom(seed));
    clk        = 1'b0;
    rst        = 1'b1;
    stall_in   = 1'b0;
    stall_mode = 1'b0;
    irq        = 3'h0;
    dut_in     = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < 200; i++)
      issue(make_ir(data_types[$urandom_range(0, 4)], 4'($urandom), 15'($urandom),
                    1'($urandom), $urandom), 3'h0, $urandom, $urandom);
    close_test("alu and data moves");

    for (int i = 0; i < 120; i++)
    begin
      a = $urandom;
      b = ($urandom_range(0, 3) == 0) ? a : $urandom; // equal operands now and then
      issue(make_ir(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0), 3'h0, a, b);
      issue(make_ir(T_BRANCH, 4'($urandom_range(0, 10)), 15'($urandom), 1'b0, $urandom),
            3'h0, $urandom, $urandom);
      if (i % 4 == 0)
        issue(make_ir(T_JUMP, 4'h0, 15'($urandom), 1'($urandom), $urandom),
              3'h0, $urandom, $urandom);
    end
    close_test("compare and branch");

    for (int i = 0; i < 40; i++)
    begin
      b  = ($urandom_range(0, 3) == 0) ? 32'h0 : $urandom;
      op = {(b != 32'h0) && ($urandom_range(0, 1) != 0), 3'($urandom_range(0, 2))};
      issue(make_ir($urandom_range(0, 1) ? T_INTU : T_INT, op, 15'($urandom), 1'b0, 32'h0),
            3'h0, $urandom, b);
    end
    close_test("multiply and divide");

    stall_mode = 1'b1;
    for (int i = 0; i < 100; i++)
      issue(make_ir(hold_types[$urandom_range(0, 3)], 4'($urandom_range(0, 10)),
                    15'($urandom), 1'($urandom), $urandom), 3'h0, $urandom, $urandom);
    close_test("stall hold");

    lvl = 3'($urandom_range(1, 7));
    issue(make_ir(T_INH, 4'h3, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0); // sti
    issue(make_ir(T_INH, 4'h0, 15'h0, 1'b0, 32'h0), lvl, 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h3, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h2, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0); // cli
    issue(make_ir(T_INH, 4'h0, 15'h0, 1'b0, 32'h0), lvl, 32'h0, 32'h0);
    for (int k = 0; k < 4; k++)
      issue(make_ir(T_INH, 4'h1, 15'(k), 1'b0, 32'h0), 3'h0, 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h1, 15'h0, 1'b1, $urandom & 32'hffffffc0), 3'h0, 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h3, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h0, 15'h0, 1'b0, 32'h0), 3'($urandom_range(1, 7)), 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h1, 15'($urandom), 1'b0, 32'h0), 3'h0, 32'h0, 32'h0);
    issue(make_ir(T_INH, 4'h5, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0); // soft reset
    issue(make_ir(T_INH, 4'h4, 15'h0, 1'b0, 32'h0), 3'h0, 32'h0, 32'h0);
    close_test("privileged control");

    chk.report_counts();
    if (chk.tests_failed == 0 && chk.errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
